// File: Makefile
# Verilator build and run of the memory subsystem testbench.
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := mem_subsystem_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard source/*.sv tests/*.sv)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes.
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the test result.
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
source/mem_op_pkg.sv
source/dbus_pkg.sv
source/amo_alu.sv
source/data_ram.sv
source/mem_unit.sv
source/mem_subsystem.sv
tests/mem_subsystem_tb.sv

// File: source/amo_alu.sv
// atomic alu. computes the new memory word for a word atomic.
`timescale 1ns/1ps
module amo_alu (
  input  mem_op_pkg::amo_op_e op,
  input  mem_op_pkg::word_t   mem_word,
  input  mem_op_pkg::word_t   operand,
  output mem_op_pkg::word_t   result
);
  import mem_op_pkg::*;

  logic signed_less;
  logic unsigned_less;

  // comparisons shared by min and max.
  assign signed_less   = $signed(mem_word) < $signed(operand);
  assign unsigned_less = mem_word < operand;

  always_comb begin
    case (op)
      // swap stores the operand.
      amo_swap: result = operand;
      amo_add:  result = mem_word + operand;
      amo_xor:  result = mem_word ^ operand;
      amo_and:  result = mem_word & operand;
      amo_or:   result = mem_word | operand;
      // two's complement order.
      amo_min: begin
        result = signed_less ? mem_word : operand;
      end
      amo_max: begin
        result = signed_less ? operand : mem_word;
      end
      // plain unsigned order.
      amo_minu: begin
        result = unsigned_less ? mem_word : operand;
      end
      amo_maxu: begin
        result = unsigned_less ? operand : mem_word;
      end
      // unknown code leaves the word as it was.
      default: result = mem_word;
    endcase
  end

endmodule

// File: source/data_ram.sv
// data ram. word-addressed bus slave with wait states and atomic updates.
`timescale 1ns/1ps
module data_ram #(
  parameter int mem_words   = 1024,
  parameter int wait_states = 1
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                dvalid,
  input  dbus_pkg::dbus_req_t dreq,
  output logic                dready,
  output dbus_pkg::dbus_rsp_t drsp
);
  import mem_op_pkg::*;
  import dbus_pkg::*;

  // index and counter widths, at least one bit each.
  localparam int idx_bits   = (mem_words > 1) ? $clog2(mem_words) : 1;
  localparam int count_bits = (wait_states > 0) ? $clog2(wait_states + 1) : 1;

  word_t                 mem [mem_words];
  logic [idx_bits-1:0]   index;
  logic [count_bits-1:0] count;
  logic                  expire;
  logic                  handshake;
  word_t                 amo_result;

  // word index, wrapping at the ram depth.
  assign index = idx_bits'((dreq.addr >> 2) % mem_words);

  // last wait cycle of a pending transfer.
  assign expire = dvalid && !dready && (count == count_bits'(wait_states));

  // transfer completes in the single dready cycle.
  assign handshake = dvalid && dready;

  // wait counter and ready pulse.
  always_ff @(posedge clock) begin
    if (reset) begin
      count  <= '0;
      dready <= 1'b0;
    end else begin
      // ready comes one cycle after the count runs out.
      dready <= expire;
      if (!dvalid || dready || expire) begin
        count <= '0;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  // new word for an atomic, from the old word read out.
  amo_alu alu0 (
    .op       (dreq.amo_op),
    .mem_word (drsp.rdata),
    .operand  (dreq.wdata),
    .result   (amo_result)
  );

  // synchronous read ahead of the handshake.
  always_ff @(posedge clock) begin
    if (reset) begin
      drsp <= dbus_rsp_none;
    end else if (expire) begin
      // old word, held through the handshake cycle.
      drsp.rdata <= mem[index];
    end
  end

  // update in the handshake cycle.
  always_ff @(posedge clock) begin
    if (handshake) begin
      if (dreq.amo) begin
        // read-modify-write of the whole word.
        mem[index] <= amo_result;
      end else if (dreq.write) begin
        // only lanes with a strobe change.
        for (int i = 0; i < 4; i++) begin
          if (dreq.wstb[i]) begin
            mem[index][8*i +: 8] <= dreq.wdata[8*i +: 8];
          end
        end
      end
    end
  end

endmodule

// File: source/dbus_pkg.sv
// data bus package. word, strobe and transfer structs of the data bus.
package dbus_pkg;

  // one write strobe per byte lane.
  typedef logic [3:0] strobe_t;

  // bus request, held stable while dvalid is high.
  typedef struct packed {
    // byte address, low two bits ignored by the slave.
    mem_op_pkg::word_t   addr;
    // store data already steered to its byte lanes.
    mem_op_pkg::word_t   wdata;
    strobe_t             wstb;
    // set for stores.
    logic                write;
    // set for atomic read-modify-write.
    logic                amo;
    mem_op_pkg::amo_op_e amo_op;
  } dbus_req_t;

  // bus response, valid in the handshake cycle.
  typedef struct packed {
    // old word at the address, for loads and atomics.
    mem_op_pkg::word_t rdata;
  } dbus_rsp_t;

  // bus response with nothing read.
  localparam dbus_rsp_t dbus_rsp_none = '{rdata: 32'h0};

  // all four byte lanes enabled.
  localparam strobe_t strobe_all = 4'b1111;

endpackage

// File: source/mem_op_pkg.sv
// memory operation package. core-side operation codes and the request struct.
package mem_op_pkg;

  // one data or address word.
  typedef logic [31:0] word_t;

  // load and store codes, used when the request is not atomic.
  typedef enum logic [3:0] {
    op_lb  = 4'd0,
    op_lh  = 4'd1,
    op_lw  = 4'd2,
    op_lbu = 4'd3,
    op_lhu = 4'd4,
    op_sb  = 4'd5,
    op_sh  = 4'd6,
    op_sw  = 4'd7
  } ls_op_e;

  // word atomic codes, used when the request's amo bit is set.
  typedef enum logic [3:0] {
    amo_swap = 4'd0,
    amo_add  = 4'd1,
    amo_xor  = 4'd2,
    amo_and  = 4'd3,
    amo_or   = 4'd4,
    amo_min  = 4'd5,
    amo_max  = 4'd6,
    amo_minu = 4'd7,
    amo_maxu = 4'd8
  } amo_op_e;

  // one 4-bit operation field, read as ls or amo by the amo bit.
  typedef union packed {
    ls_op_e  ls;
    amo_op_e amo;
  } mem_op_u;

  // request from the core, held until the acknowledge.
  typedef struct packed {
    word_t   addr;
    mem_op_u op;
    // selects the atomic reading of op.
    logic    amo;
    word_t   data;
  } mem_req_t;

endpackage

// File: source/mem_subsystem.sv
// memory subsystem. memory unit joined to the data ram over the data bus.
`timescale 1ns/1ps
module mem_subsystem #(
  parameter int mem_words   = 1024,
  parameter int wait_states = 1
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 req_valid,
  input  mem_op_pkg::mem_req_t req,
  output logic                 ack_valid,
  output mem_op_pkg::word_t    ack_data
);
  import dbus_pkg::*;

  // data bus between the unit and the ram.
  logic      dvalid;
  dbus_req_t dreq;
  logic      dready;
  dbus_rsp_t drsp;

  // request sequencer, lane steering and load extraction.
  mem_unit unit0 (
    .clock     (clock),
    .reset     (reset),
    .req_valid (req_valid),
    .req       (req),
    .ack_valid (ack_valid),
    .ack_data  (ack_data),
    .dvalid    (dvalid),
    .dreq      (dreq),
    .dready    (dready),
    .drsp      (drsp)
  );

  // tightly coupled ram with fixed wait states.
  data_ram #(
    .mem_words   (mem_words),
    .wait_states (wait_states)
  ) ram0 (
    .clock  (clock),
    .reset  (reset),
    .dvalid (dvalid),
    .dreq   (dreq),
    .dready (dready),
    .drsp   (drsp)
  );

endmodule

// File: source/mem_unit.sv
// memory unit. turns one core request into one data bus transfer.
`timescale 1ns/1ps
module mem_unit (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 req_valid,
  input  mem_op_pkg::mem_req_t req,
  output logic                 ack_valid,
  output mem_op_pkg::word_t    ack_data,
  output logic                 dvalid,
  output dbus_pkg::dbus_req_t  dreq,
  input  logic                 dready,
  input  dbus_pkg::dbus_rsp_t  drsp
);
  import mem_op_pkg::*;
  import dbus_pkg::*;

  // waiting for a request, or waiting for the bus.
  typedef enum logic {
    st_wait_req,
    st_wait_rsp
  } state_e;

  state_e     state;
  logic       accept;
  logic       done;
  logic       is_store;
  strobe_t    stb_next;
  word_t      wdata_next;
  strobe_t    stb_q;
  logic       write_q;
  word_t      addr_q;
  word_t      wdata_q;
  mem_op_u    op_q;
  logic       amo_q;
  logic [1:0] offset;
  logic [7:0] byte_sel;
  logic [15:0] half_sel;
  word_t      load_data;

  // the ack cycle blocks a new accept, so a held request is taken once.
  assign accept = (state == st_wait_req) && req_valid && !ack_valid;
  assign done   = (state == st_wait_rsp) && dvalid && dready;

  assign is_store = !req.amo && (req.op.ls inside {op_sb, op_sh, op_sw});

  // store lane steering from the live request.
  always_comb begin
    stb_next   = strobe_all;
    wdata_next = req.data;
    if (!req.amo) begin
      case (req.op.ls)
        op_sb: begin
          // one lane, byte copied to all four.
          stb_next   = strobe_t'(4'b0001 << req.addr[1:0]);
          wdata_next = {4{req.data[7:0]}};
        end
        op_sh: begin
          stb_next   = req.addr[1] ? 4'b1100 : 4'b0011;
          wdata_next = {2{req.data[15:0]}};
        end
        op_sw: begin
          stb_next   = strobe_all;
          wdata_next = req.data;
        end
        // loads write nothing.
        default: stb_next = 4'b0000;
      endcase
    end
  end

  // load extraction works from the registered op and offset.
  assign offset   = addr_q[1:0];
  assign byte_sel = drsp.rdata[8*offset +: 8];
  assign half_sel = offset[1] ? drsp.rdata[31:16] : drsp.rdata[15:0];

  always_comb begin
    // atomics return the old word as is.
    load_data = drsp.rdata;
    if (!amo_q) begin
      case (op_q.ls)
        op_lb:   load_data = {{24{byte_sel[7]}}, byte_sel};
        op_lbu:  load_data = {24'h0, byte_sel};
        op_lh:   load_data = {{16{half_sel[15]}}, half_sel};
        op_lhu:  load_data = {16'h0, half_sel};
        op_lw:   load_data = drsp.rdata;
        // stores acknowledge with zero.
        default: load_data = '0;
      endcase
    end
  end

  // sequencer state and bus control.
  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= st_wait_req;
      ack_valid <= 1'b0;
      dvalid    <= 1'b0;
      stb_q     <= '0;
      write_q   <= 1'b0;
    end else begin
      // one-cycle acknowledge right after the handshake.
      ack_valid <= done;
      case (state)
        st_wait_req: begin
          if (accept) begin
            state   <= st_wait_rsp;
            dvalid  <= 1'b1;
            stb_q   <= stb_next;
            write_q <= is_store;
          end
        end
        default: begin
          if (done) begin
            state   <= st_wait_req;
            dvalid  <= 1'b0;
            stb_q   <= '0;
            write_q <= 1'b0;
          end
        end
      endcase
    end
  end

  // request payload, captured so the requester may let go after the ack.
  always_ff @(posedge clock) begin
    if (accept) begin
      addr_q  <= req.addr;
      wdata_q <= wdata_next;
      op_q    <= req.op;
      amo_q   <= req.amo;
    end
    if (done) begin
      ack_data <= load_data;
    end
  end

  // bus request built from the held fields.
  always_comb begin
    dreq.addr   = addr_q;
    dreq.wdata  = wdata_q;
    dreq.wstb   = stb_q;
    dreq.write  = write_q;
    dreq.amo    = amo_q;
    dreq.amo_op = op_q.amo;
  end

endmodule

// File: tests/mem_subsystem_tb.sv
// memory subsystem testbench. directed load, store and atomic tests against a memory model.
`timescale 1ns/1ps
module mem_subsystem_tb;
  import mem_op_pkg::*;

  localparam int mem_words    = 64;
  localparam int wait_states  = 2;
  localparam int reset_cycles = 16;
  localparam int rt_count     = 24;
  localparam int amo_rounds   = 3;
  // quiet check, round trips, bytes, halves, atomics, back-to-back.
  localparam int request_slots = 1 + 2 * rt_count + 17 + 9 + 27 * amo_rounds + 8;
  localparam int timeout_cycles = request_slots * (wait_states + 6) + reset_cycles;
  localparam amo_op_e amo_ops [9] = '{amo_swap, amo_add, amo_xor, amo_and, amo_or,
                                      amo_min, amo_max, amo_minu, amo_maxu};

  logic     clock = 1'b0;
  logic     reset;
  logic     req_valid;
  mem_req_t req;
  logic     ack_valid;
  word_t    ack_data;

  // expected memory contents.
  word_t model [mem_words];
  word_t lfsr_state = 32'd28;
  int    cycles = 0;
  int    ack_count = 0;
  int    issued_count = 0;

  mem_subsystem #(
    .mem_words   (mem_words),
    .wait_states (wait_states)
  ) dut0 (
    .clock     (clock),
    .reset     (reset),
    .req_valid (req_valid),
    .req       (req),
    .ack_valid (ack_valid),
    .ack_data  (ack_data)
  );

  always #2 clock = ~clock;

  // run limit.
  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout after %0d cycles, the DUT stopped acknowledging requests", cycles);
      $display("Checks failed");
      $fatal(1, "timeout");
    end
  end

  // every acknowledge pulse, sampled mid-cycle.
  always @(negedge clock) begin
    if (!reset && ack_valid) begin
      ack_count <= ack_count + 1;
    end
  end

  // galois lfsr, right shifting.
  function automatic word_t lfsr_next(input word_t s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit taken.
  function automatic word_t take_bits(input int n);
    word_t bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return bits;
  endfunction

  // word slot of a byte address, wrapping at the depth.
  function automatic int model_index(input word_t addr);
    return int'((addr >> 2) % word_t'(mem_words));
  endfunction

  function automatic word_t model_load(input ls_op_e op, input word_t addr);
    word_t      w;
    logic [7:0] b;
    logic [15:0] h;
    word_t      r;
    w = model[model_index(addr)];
    b = 8'(w >> (8 * addr[1:0]));
    // bit 1 picks the upper half.
    h = addr[1] ? w[31:16] : w[15:0];
    case (op)
      op_lb:   r = {{24{b[7]}}, b};
      op_lbu:  r = {24'h0, b};
      op_lh:   r = {{16{h[15]}}, h};
      op_lhu:  r = {16'h0, h};
      default: r = w;
    endcase
    return r;
  endfunction

  function automatic void model_store(input ls_op_e op, input word_t addr, input word_t data);
    int i;
    i = model_index(addr);
    case (op)
      op_sb: model[i][8*addr[1:0] +: 8] = data[7:0];
      op_sh: begin
        if (addr[1]) begin
          model[i][31:16] = data[15:0];
        end else begin
          model[i][15:0] = data[15:0];
        end
      end
      default: model[i] = data;
    endcase
  endfunction

  // new memory word of an atomic.
  function automatic word_t amo_model(input amo_op_e op, input word_t old, input word_t val);
    int a;
    int b;
    word_t r;
    a = old;
    b = val;
    case (op)
      amo_swap: r = val;
      amo_add:  r = old + val;
      amo_xor:  r = old ^ val;
      amo_and:  r = old & val;
      amo_or:   r = old | val;
      amo_min:  r = (a <= b) ? old : val;
      amo_max:  r = (a >= b) ? old : val;
      amo_minu: r = (old <= val) ? old : val;
      default:  r = (old >= val) ? old : val;
    endcase
    return r;
  endfunction

  task automatic check_word(input word_t actual, input word_t expected, input string what);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s gave %h, expected %h", $time, what, actual, expected);
      $display("Checks failed");
      $fatal(1, "data mismatch");
    end
  endtask

  // called on a falling edge, returns on the falling edge after the ack cycle,
  // or one idle cycle later when the request is dropped.
  task automatic issue(input mem_req_t r, input bit hold, output word_t data);
    req = r;
    req_valid = 1'b1;
    issued_count++;
    @(negedge clock);
    while (!ack_valid) begin
      @(negedge clock);
    end
    data = ack_data;
    @(negedge clock);
    // held requests are replaced by the next issue.
    if (!hold) begin
      req_valid = 1'b0;
      @(negedge clock);
    end
  endtask

  task automatic do_store(input ls_op_e op, input word_t addr, input word_t data, input bit hold);
    mem_req_t r;
    word_t    ack;
    r = '0;
    r.addr = addr;
    r.op.ls = op;
    r.data = data;
    issue(r, hold, ack);
    // stores ack with zero.
    check_word(ack, '0, $sformatf("%s to %h", op.name(), addr));
    model_store(op, addr, data);
  endtask

  task automatic do_load(input ls_op_e op, input word_t addr, input bit hold);
    mem_req_t r;
    word_t    ack;
    r = '0;
    r.addr = addr;
    r.op.ls = op;
    issue(r, hold, ack);
    check_word(ack, model_load(op, addr), $sformatf("%s from %h", op.name(), addr));
  endtask

  task automatic do_amo(input amo_op_e op, input word_t addr, input word_t operand);
    mem_req_t r;
    word_t    ack;
    word_t    old;
    r = '0;
    r.addr = addr;
    r.op.amo = op;
    r.amo = 1'b1;
    r.data = operand;
    old = model[model_index(addr)];
    issue(r, 1'b0, ack);
    check_word(ack, old, $sformatf("%s at %h", op.name(), addr));
    model[model_index(addr)] = amo_model(op, old, operand);
  endtask

  // no acknowledge without a request.
  task automatic test_idle();
    for (int i = 0; i < wait_states + 6; i++) begin
      @(negedge clock);
      if (ack_valid !== 1'b0) begin
        $display("acknowledge raised at %0t ns with no request pending", $time);
        $display("Checks failed");
        $fatal(1, "spurious acknowledge");
      end
    end
  endtask

  task automatic test_round_trip();
    word_t addr;
    for (int i = 0; i < rt_count; i++) begin
      // word index up to 255, so most addresses wrap.
      addr = take_bits(8) << 2;
      do_store(op_sw, addr, take_bits(32), 1'b0);
      // alias one ram depth higher hits the same word.
      do_load(op_lw, addr + word_t'(mem_words * 4), 1'b0);
    end
  endtask

  task automatic test_bytes();
    word_t base;
    word_t data;
    base = take_bits(6) << 2;
    do_store(op_sw, base, take_bits(32), 1'b0);
    for (int lane = 0; lane < 4; lane++) begin
      data = take_bits(32);
      // odd lanes negative.
      data[7] = lane[0];
      do_store(op_sb, base + word_t'(lane), data, 1'b0);
      do_load(op_lw, base, 1'b0);
    end
    for (int lane = 0; lane < 4; lane++) begin
      do_load(op_lb, base + word_t'(lane), 1'b0);
      do_load(op_lbu, base + word_t'(lane), 1'b0);
    end
  endtask

  task automatic test_halves();
    word_t base;
    word_t data;
    base = take_bits(6) << 2;
    do_store(op_sw, base, take_bits(32), 1'b0);
    for (int off = 0; off < 4; off += 2) begin
      data = take_bits(32);
      data[15] = (off == 0);
      do_store(op_sh, base + word_t'(off), data, 1'b0);
      do_load(op_lw, base, 1'b0);
    end
    for (int off = 0; off < 4; off += 2) begin
      do_load(op_lh, base + word_t'(off), 1'b0);
      do_load(op_lhu, base + word_t'(off), 1'b0);
    end
  endtask

  task automatic test_atomics();
    word_t addr;
    word_t old;
    word_t operand;
    for (int round = 0; round < amo_rounds; round++) begin
      for (int k = 0; k < 9; k++) begin
        addr = take_bits(6) << 2;
        old = take_bits(32);
        operand = take_bits(32);
        // rounds 1 and 2 force opposite signs.
        if (round == 1) begin
          old[31] = 1'b1;
          operand[31] = 1'b0;
        end else if (round == 2) begin
          old[31] = 1'b0;
          operand[31] = 1'b1;
        end
        do_store(op_sw, addr, old, 1'b0);
        do_amo(amo_ops[k], addr, operand);
        do_load(op_lw, addr, 1'b0);
      end
    end
  endtask

  // each request follows the previous ack with no idle cycle.
  task automatic test_back_to_back();
    word_t base;
    base = take_bits(6) << 2;
    do_store(op_sw, base, take_bits(32), 1'b1);
    do_load(op_lw, base, 1'b1);
    do_store(op_sb, base + 32'd3, take_bits(32), 1'b1);
    do_load(op_lbu, base + 32'd3, 1'b1);
    do_store(op_sh, base, take_bits(32), 1'b1);
    do_load(op_lh, base, 1'b1);
    do_store(op_sw, base, take_bits(32), 1'b1);
    do_load(op_lw, base, 1'b0);
    // a request taken twice would acknowledge within this window.
    repeat (wait_states + 4) @(negedge clock);
    check_word(word_t'(ack_count), word_t'(issued_count), "acknowledge count");
  endtask

  initial begin
    reset = 1'b1;
    req_valid = 1'b0;
    req = '0;
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    test_idle();
    test_round_trip();
    test_bytes();
    test_halves();
    test_atomics();
    test_back_to_back();
    $display("All checks passed");
    $finish;
  end

endmodule
